// ==== Makefile ====
# Verilator build and run of the dside testbench

SRCS = dside_pkg.sv dside_cmd_issue.sv dside_pending_fifo.sv dside_data_mem.sv \
       dside_retire.sv dside_subsystem.sv dside_chk.sv tb_clkgen.sv tb_dside.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_dside: $(SRCS) dside_subsystem.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dside \
	  -f dside_subsystem.f

run: obj_dir/Vtb_dside
	./obj_dir/Vtb_dside +verilator+error+limit+1000 | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dside_chk.sv ====
// --------------------------------------------------
// bound into dside_subsystem; each record is judged
// one cycle after it appears, against a shadow memory
// --------------------------------------------------
module dside_chk
  import dside_pkg::*;
#(
  parameter int unsigned MemWords   = 256,
  parameter int unsigned RspLatency = 2,
  parameter int unsigned PendDepth  = 4
) (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        cmd_valid_i,
  input dmem_req_t   cmd_i,
  input logic        cmd_ready_i,
  input logic        rec_valid_i,
  input access_rec_t rec_i
);

  int unsigned fail_cnt = 0;  // read by the testbench
  data_t       shadow_q [MemWords];
  dmem_req_t   cmd_q [$];     // transferred, no record yet
  int unsigned stamp_q [$];   // cycle of each transfer
  int unsigned cycle_q;
  int unsigned inflight_q;
  logic        live_q;
  logic        store_xfer_q;
  logic        retry_q;
  logic        rec_seen_q;
  logic        order_ok_q;
  logic        value_ok_q;
  logic        xfer;

  assign xfer = cmd_valid_i & cmd_ready_i;

  initial begin
    for (int i = 0; i < MemWords; i++) begin
      shadow_q[i] = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    dmem_req_t   head;
    int unsigned stamp;
    int unsigned idx;
    logic        oob;
    data_t       exp_data;
    if (!rst_ni) begin
      cycle_q      <= 0;
      inflight_q   <= 0;
      live_q       <= 1'b0;
      store_xfer_q <= 1'b0;
      retry_q      <= 1'b0;
      rec_seen_q   <= 1'b0;
      order_ok_q   <= 1'b1;
      value_ok_q   <= 1'b1;
      cmd_q.delete();
      stamp_q.delete();
    end else begin
      cycle_q      <= cycle_q + 1;
      live_q       <= 1'b1;
      store_xfer_q <= xfer & cmd_i.we;
      retry_q      <= store_xfer_q & cmd_valid_i;  // command waiting out the recovery
      rec_seen_q   <= rec_valid_i;
      inflight_q   <= inflight_q + 32'(xfer) - 32'(rec_valid_i);
      if (rec_valid_i) begin
        order_ok_q <= 1'b0;
        value_ok_q <= 1'b0;
        if (cmd_q.size() > 0) begin
          head     = cmd_q.pop_front();
          stamp    = stamp_q.pop_front();
          idx      = 32'(head.addr[31:2]);
          oob      = (idx >= MemWords);
          exp_data = head.we ? head.wdata : (oob ? '0 : shadow_q[idx]);
          order_ok_q <= (rec_i.we == head.we) && (rec_i.addr == head.addr) &&
                        (rec_i.be == head.be) && (cycle_q - stamp == RspLatency + 1);
          value_ok_q <= (rec_i.data == exp_data) && (rec_i.err == oob);
          if (head.we && !oob) begin
            for (int b = 0; b < 4; b++) begin
              if (head.be[b]) begin
                shadow_q[idx][8*b +: 8] <= head.wdata[8*b +: 8];
              end
            end
          end
        end
      end
      if (xfer) begin
        cmd_q.push_back(cmd_i);
        stamp_q.push_back(cycle_q);
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i) !live_q |-> !rec_valid_i)
    else begin
      $error("record valid during reset or on the first cycle after it");
      fail_cnt++;
    end

  a_idle_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    live_q && inflight_q == 0 |-> cmd_ready_i)
    else begin
      $error("cmd_ready_o low with nothing in flight");
      fail_cnt++;
    end

  a_recovery: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_xfer_q |-> !cmd_ready_i)
    else begin
      $error("cmd_ready_o high on the cycle after a store");
      fail_cnt++;
    end

  a_retry: assert property (@(posedge clk_i) disable iff (!rst_ni) retry_q |-> cmd_ready_i)
    else begin
      $error("held command not accepted once write recovery ended");
      fail_cnt++;
    end

  a_inflight: assert property (@(posedge clk_i) disable iff (!rst_ni) inflight_q <= PendDepth)
    else begin
      $error("more than PendDepth accesses in flight");
      fail_cnt++;
    end

  a_rec_order: assert property (@(posedge clk_i) disable iff (!rst_ni) rec_seen_q |-> order_ok_q)
    else begin
      $error("record out of order, mismatched or off the expected latency");
      fail_cnt++;
    end

  a_rec_value: assert property (@(posedge clk_i) disable iff (!rst_ni) rec_seen_q |-> value_ok_q)
    else begin
      $error("record data or err differs from the shadow memory");
      fail_cnt++;
    end

endmodule

bind dside_subsystem dside_chk #(
  .MemWords   (MemWords),
  .RspLatency (RspLatency),
  .PendDepth  (PendDepth)
) dside_chk_inst (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cmd_valid_i (cmd_valid_i),
  .cmd_i       (cmd_i),
  .cmd_ready_i (cmd_ready_o),
  .rec_valid_i (rec_valid_o),
  .rec_i       (rec_o)
);

// ==== dside_cmd_issue.sv ====
// --------------------------------------------------
// req follows cmd_valid_i directly, so a command
// transfers on the same cycle the bus grants it
// --------------------------------------------------
module dside_cmd_issue
  import dside_pkg::*;
#(
  parameter int unsigned PendDepth = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cmd_valid_i,
  input  dmem_req_t cmd_i,
  output logic      cmd_ready_o,
  input  logic      pend_full_i,
  input  logic      pop_i,
  output logic      req_o,
  output dmem_req_t req_data_o,
  input  logic      gnt_i,
  output logic      push_o
);

  localparam int unsigned CntW = $clog2(PendDepth + 1);

  logic [CntW-1:0] inflight_q;
  logic            limit_hit;
  logic            room;

  // granted but not yet retired, a backstop next to the queue's own full flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
    end else begin
      case ({push_o, pop_i})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  assign limit_hit = (inflight_q >= CntW'(PendDepth));
  assign room      = ~pend_full_i & ~limit_hit;

  assign req_o       = cmd_valid_i & room;
  assign req_data_o  = cmd_i;            // command is the request
  assign cmd_ready_o = gnt_i & room;
  assign push_o      = req_o & gnt_i;    // granted cycle

endmodule

// ==== dside_data_mem.sv ====
// --------------------------------------------------
// word memory, RspLatency >= 1; no grant the cycle
// after a granted store; index >= MemWords is an error
// --------------------------------------------------
module dside_data_mem
  import dside_pkg::*;
#(
  parameter int unsigned MemWords   = 256,
  parameter int unsigned RspLatency = 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  dmem_req_t req_data_i,
  output logic      gnt_o,
  output logic      rvalid_o,
  output dmem_rsp_t rsp_o
);

  localparam int unsigned IdxW = $clog2(MemWords);

  data_t                       mem_q [MemWords];
  logic                        wr_recov_q;
  logic [RspLatency-1:0]       valid_q;
  dmem_rsp_t [RspLatency-1:0]  rsp_q;
  logic                        granted;
  logic [29:0]                 word_idx;
  logic                        in_range;
  dmem_rsp_t                   rsp_new;

  initial begin
    for (int i = 0; i < MemWords; i++) begin
      mem_q[i] = '0;
    end
  end

  assign gnt_o    = ~wr_recov_q;  // address plays no part
  assign granted  = req_i & gnt_o;
  assign word_idx = req_data_i.addr[31:2];
  assign in_range = ({2'b00, word_idx} < 32'(MemWords));

  // response is fixed at grant time
  always_comb begin
    rsp_new.err   = ~in_range;
    rsp_new.rdata = '0;
    if (in_range && !req_data_i.we) begin
      rsp_new.rdata = mem_q[word_idx[IdxW-1:0]];
    end
  end

  always_ff @(posedge clk_i) begin
    if (granted && req_data_i.we && in_range) begin
      for (int b = 0; b < 4; b++) begin
        if (req_data_i.be[b]) begin
          mem_q[word_idx[IdxW-1:0]][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_recov_q <= 1'b0;
      valid_q    <= '0;
    end else begin
      wr_recov_q <= granted & req_data_i.we;
      valid_q[0] <= granted;
      for (int s = 1; s < RspLatency; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  // response payload shifts alongside the valid bits
  always_ff @(posedge clk_i) begin
    rsp_q[0] <= rsp_new;
    for (int s = 1; s < RspLatency; s++) begin
      rsp_q[s] <= rsp_q[s-1];
    end
  end

  assign rvalid_o = valid_q[RspLatency-1];
  assign rsp_o    = rsp_q[RspLatency-1];

endmodule

// ==== dside_pending_fifo.sv ====
// --------------------------------------------------
// holds granted requests in grant order until their
// responses return; pop on an empty queue is illegal
// --------------------------------------------------
module dside_pending_fifo
  import dside_pkg::*;
#(
  parameter int unsigned PendDepth = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  dmem_req_t push_data_i,
  input  logic      pop_i,
  output dmem_req_t head_o,
  output logic      full_o
);

  localparam int unsigned PtrW = $clog2(PendDepth);
  localparam int unsigned CntW = $clog2(PendDepth + 1);

  dmem_req_t       store_q [PendDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            do_push;
  logic            do_pop;

  assign full_o  = (cnt_q == CntW'(PendDepth));
  assign do_push = push_i & (~full_o | pop_i);  // full queue still takes a push with a pop
  assign do_pop  = pop_i;
  assign head_o  = store_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(PendDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(PendDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      store_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// ==== dside_pkg.sv ====
// --------------------------------------------------
// types shared by the data-side port and its recorder
// every access is one aligned 32-bit word, no splits
// --------------------------------------------------
package dside_pkg;

  typedef logic [31:0] addr_t;  // byte address on the data bus
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;    // one enable per byte lane

  // command from outside and request on the bus share one layout
  typedef struct packed {
    logic  we;
    addr_t addr;
    be_t   be;
    data_t wdata;
  } dmem_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } dmem_rsp_t;

  // one retired access as seen on the bus
  typedef struct packed {
    logic  we;
    addr_t addr;
    be_t   be;
    data_t data;  // store data or load data
    logic  err;
  } access_rec_t;

endpackage

// ==== dside_retire.sv ====
// --------------------------------------------------
// rvalid cannot stall, so the queue head is popped on
// every response; the record is one cycle behind it
// --------------------------------------------------
module dside_retire
  import dside_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rvalid_i,
  input  dmem_rsp_t   rsp_i,
  input  dmem_req_t   head_i,
  output logic        pop_o,
  output logic        rec_valid_o,
  output access_rec_t rec_o
);

  logic        rec_valid_q;
  access_rec_t rec_q;
  access_rec_t rec_d;

  assign pop_o = rvalid_i;

  always_comb begin
    rec_d.we   = head_i.we;
    rec_d.addr = head_i.addr;
    rec_d.be   = head_i.be;
    rec_d.data = head_i.we ? head_i.wdata : rsp_i.rdata;  // stores report what was written
    rec_d.err  = rsp_i.err;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_valid_q <= 1'b0;
    end else begin
      rec_valid_q <= rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvalid_i) begin
      rec_q <= rec_d;
    end
  end

  assign rec_valid_o = rec_valid_q;
  assign rec_o       = rec_q;

endmodule

// ==== dside_subsystem.f ====
dside_pkg.sv
dside_cmd_issue.sv
dside_pending_fifo.sv
dside_data_mem.sv
dside_retire.sv
dside_subsystem.sv
dside_chk.sv
tb_clkgen.sv
tb_dside.sv

// ==== dside_subsystem.sv ====
// --------------------------------------------------
// command to record takes RspLatency+1 cycles;
// PendDepth must be at least RspLatency+1
// --------------------------------------------------
module dside_subsystem
  import dside_pkg::*;
#(
  parameter int unsigned MemWords   = 256,
  parameter int unsigned RspLatency = 2,
  parameter int unsigned PendDepth  = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cmd_valid_i,
  input  dmem_req_t   cmd_i,
  output logic        cmd_ready_o,
  output logic        rec_valid_o,
  output access_rec_t rec_o
);

  logic      dmem_req;
  logic      dmem_gnt;
  logic      dmem_rvalid;
  dmem_req_t bus_req;
  dmem_rsp_t bus_rsp;
  logic      pend_push;
  logic      pend_pop;
  logic      pend_full;
  dmem_req_t pend_head;

  dside_cmd_issue #(
    .PendDepth (PendDepth)
  ) dside_cmd_issue_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_ready_o (cmd_ready_o),
    .pend_full_i (pend_full),
    .pop_i       (pend_pop),
    .req_o       (dmem_req),
    .req_data_o  (bus_req),
    .gnt_i       (dmem_gnt),
    .push_o      (pend_push)
  );

  dside_pending_fifo #(
    .PendDepth (PendDepth)
  ) dside_pending_fifo_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (pend_push),
    .push_data_i (bus_req),
    .pop_i       (pend_pop),
    .head_o      (pend_head),
    .full_o      (pend_full)
  );

  dside_data_mem #(
    .MemWords   (MemWords),
    .RspLatency (RspLatency)
  ) dside_data_mem_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (dmem_req),
    .req_data_i (bus_req),
    .gnt_o      (dmem_gnt),
    .rvalid_o   (dmem_rvalid),
    .rsp_o      (bus_rsp)
  );

  dside_retire dside_retire_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rvalid_i    (dmem_rvalid),
    .rsp_i       (bus_rsp),
    .head_i      (pend_head),
    .pop_o       (pend_pop),
    .rec_valid_o (rec_valid_o),
    .rec_o       (rec_o)
  );

endmodule

// ==== tb_clkgen.sv ====
// --------------------------------------------------
// free-running clock; reset is released a quarter
// period after the last reset edge
// --------------------------------------------------
module tb_clkgen #(
  parameter int unsigned Period    = 40,
  parameter int unsigned RstCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(Period / 2) clk_o = ~clk_o;
    end
  end

  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    #(Period / 4) rst_no = 1'b1;  // clear of the drive point after the edge
  end

endmodule

// ==== tb_dside.sv ====
// --------------------------------------------------
// LCG stimulus for dside_subsystem; the bound checker
// judges every record, this top counts and reports
// --------------------------------------------------
module tb_dside;
  import dside_pkg::*;

  localparam int unsigned MemWords   = 256;
  localparam int unsigned RspLatency = 2;
  localparam int unsigned PendDepth  = 4;
  localparam int unsigned Timeout    = 200;  // cycles per wait
  localparam int unsigned DriveDly   = 5;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  dmem_req_t   cmd;
  logic        cmd_ready;
  logic        rec_valid;
  access_rec_t rec;

  int unsigned lcg_state = 66;
  int unsigned err_cnt   = 0;
  int unsigned test_cnt  = 0;
  int unsigned sent_cnt  = 0;
  int unsigned rec_cnt   = 0;
  int unsigned sent_mark;
  int unsigned rec_mark;
  int unsigned err_mark;

  tb_clkgen #(
    .Period    (40),
    .RstCycles (4)
  ) tb_clkgen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dside_subsystem #(
    .MemWords   (MemWords),
    .RspLatency (RspLatency),
    .PendDepth  (PendDepth)
  ) dside_subsystem_inst (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .cmd_ready_o (cmd_ready),
    .rec_valid_o (rec_valid),
    .rec_o       (rec)
  );

  always @(posedge clk) begin
    if (rec_valid) begin
      rec_cnt <= rec_cnt + 1;
    end
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {lcg_state[15:0], lcg_state[31:16]};  // weak low bits moved up
  endfunction

  function automatic dmem_req_t make_cmd(logic we, int unsigned idx, be_t be, data_t wdata);
    dmem_req_t c;
    c.we    = we;
    c.addr  = addr_t'(idx) << 2;
    c.be    = be;
    c.wdata = wdata;
    return c;
  endfunction

  function automatic int unsigned total_errors();
    return err_cnt + dside_subsystem_inst.dside_chk_inst.fail_cnt;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #DriveDly;
  endtask

  // valid stays high afterwards so commands can go back to back
  task automatic send_cmd(input dmem_req_t c);
    int unsigned waited;
    logic        taken;
    waited    = 0;
    taken     = 1'b0;
    cmd_valid = 1'b1;
    cmd       = c;
    while (!taken && waited < Timeout) begin
      taken = cmd_ready;  // settled since the last edge
      next_cycle();
      waited++;
    end
    if (taken) begin
      sent_cnt++;
    end else begin
      $display("command was not accepted within %0d cycles at time %0t", Timeout, $time);
      err_cnt++;
      cmd_valid = 1'b0;
    end
  endtask

  task automatic idle(input int unsigned n);
    cmd_valid = 1'b0;
    repeat (n) next_cycle();
  endtask

  task automatic start_test();
    sent_mark = sent_cnt;
    rec_mark  = rec_cnt;
    err_mark  = total_errors();
  endtask

  task automatic finish_test(input string name);
    int unsigned waited;
    cmd_valid = 1'b0;
    waited    = 0;
    while (rec_cnt < sent_cnt && waited < Timeout) begin
      next_cycle();
      waited++;
    end
    repeat (2) next_cycle();  // checker judges the last record one cycle late
    if (rec_cnt < sent_cnt && waited >= Timeout) begin
      $display("records did not arrive within %0d cycles at time %0t", Timeout, $time);
      err_cnt++;
    end else if (rec_cnt != sent_cnt) begin
      $display("[ERROR] %0t rec_valid_o count: got %0d, expected %0d", $time, rec_cnt, sent_cnt);
      err_cnt++;
    end
    test_cnt++;
    $display("test %-14s %0d commands, %0d records, %0d errors", name,
             sent_cnt - sent_mark, rec_cnt - rec_mark, total_errors() - err_mark);
  endtask

  initial begin
    int unsigned waited;
    int unsigned idx_q [8];
    int unsigned low;
    cmd_valid = 1'b0;
    cmd       = '0;

    start_test();
    waited = 0;
    while (!rst_n && waited < Timeout) begin
      next_cycle();
      waited++;
    end
    if (!rst_n) begin
      $display("reset was never released within %0d cycles", Timeout);
      err_cnt++;
    end
    idle(3);
    finish_test("reset");

    start_test();
    for (int k = 0; k < 8; k++) begin
      idx_q[k] = next_rand() % MemWords;
      send_cmd(make_cmd(1'b1, idx_q[k], be_t'(next_rand()), data_t'(next_rand())));
      idle(next_rand() % 3);
    end
    for (int k = 0; k < 8; k++) begin
      send_cmd(make_cmd(1'b0, idx_q[k], 4'hf, '0));
      idle(next_rand() % 3);
    end
    finish_test("store_load");

    start_test();
    for (int k = 0; k < 10; k++) begin
      send_cmd(make_cmd(1'b0, next_rand() % MemWords, 4'hf, '0));
    end
    finish_test("order_latency");

    start_test();
    for (int k = 0; k < 6; k++) begin
      send_cmd(make_cmd(1'b1, next_rand() % MemWords, 4'hf, data_t'(next_rand())));
    end
    finish_test("write_recovery");

    start_test();
    for (int k = 0; k < 3; k++) begin
      low = next_rand() % MemWords;
      send_cmd(make_cmd(1'b1, MemWords * (k + 1) + low, 4'hf, data_t'(next_rand())));
      send_cmd(make_cmd(1'b0, MemWords * (k + 1) + low, 4'hf, '0));
      send_cmd(make_cmd(1'b0, low, 4'hf, '0));  // in range, untouched by the store
      idle(1);
    end
    finish_test("range_error");

    start_test();
    for (int k = 0; k < 12; k++) begin
      send_cmd(make_cmd(1'(next_rand()), next_rand() % MemWords, be_t'(next_rand()),
                        data_t'(next_rand())));
    end
    finish_test("queue_full");

    $display("summary: %0d tests, %0d errors", test_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
